/* hw/rsp_order_defs.svh */
// Shared sizes for the response-ordering shim.
// RO_ENTRIES must be a power of two, since the ring pointers wrap naturally.
// RO_RESERVE must be at least 1 to cover the registered full flags.

`ifndef RSP_ORDER_DEFS_SVH
`define RSP_ORDER_DEFS_SVH

// Number of read tags, and separately the number of write tags
`define RO_ENTRIES 16

// Tag width follows from the tag count
`define RO_TAG_W $clog2(`RO_ENTRIES)

// Client metadata, address and data widths
`define RO_META_W 8
`define RO_ADDR_W 16
`define RO_DATA_W 32

// Free slots held back while the registered full flag catches up
`define RO_RESERVE 1

`endif

/* hw/rspOrderPkg.sv */
// Request and response types for the response-ordering shim.
// The memory side carries a tag where the client side carries metadata.

`include "rsp_order_defs.svh"

package rspOrderPkg;

    // Basic words
    typedef logic [`RO_META_W-1:0] metaT;
    typedef logic [`RO_TAG_W-1:0]  tagT;
    typedef logic [`RO_ADDR_W-1:0] addrT;
    typedef logic [`RO_DATA_W-1:0] dataT;

    // ====================
    // Client side
    // ====================

    typedef struct packed {
        addrT addr;
        metaT meta;
    } rdReqT;

    typedef struct packed {
        addrT addr;
        dataT data;
        metaT meta;
    } wrReqT;

    typedef struct packed {
        dataT data;
        metaT meta;
    } rdRspT;

    typedef struct packed {
        metaT meta;
    } wrRspT;

    // ====================
    // Memory side
    // ====================

    // The tag takes the place of the client metadata
    typedef struct packed {
        addrT addr;
        tagT  tag;
    } memRdReqT;

    typedef struct packed {
        addrT addr;
        dataT data;
        tagT  tag;
    } memWrReqT;

    typedef struct packed {
        tagT  tag;
        dataT data;
    } memRdRspT;

endpackage

/* hw/tagHeap.sv */
// Free-list store of tags with metadata kept per tag.
// alloc must only be raised while notFull is high; notFull is registered.
// Tags may be freed in any order, and only tags that are outstanding.

`timescale 1ns/1ps
`include "rsp_order_defs.svh"

module tagHeap
    import rspOrderPkg::*;
(
    input  logic clk,
    input  logic arstN,
    input  logic alloc,
    input  metaT allocMeta,
    output tagT  allocTag,
    output logic notFull,
    input  tagT  lookupTag,
    output metaT lookupMeta,
    input  logic free,
    input  tagT  freeTag
);

    localparam int Entries = `RO_ENTRIES;
    localparam int CntW = `RO_TAG_W + 1;

    typedef logic [CntW-1:0] cntT;

    tagT  freeStack [Entries];
    metaT metaMem [Entries];
    cntT  freeCnt;
    cntT  freeCntNext;
    tagT  topPos;
    tagT  pushPos;

    // The top of the stack is the next tag handed out
    assign topPos   = tagT'(freeCnt - cntT'(1));
    assign pushPos  = tagT'(freeCnt);
    assign allocTag = freeStack[topPos];

    always_comb
    begin
        freeCntNext = freeCnt;
        if (alloc && !free)
        begin
            freeCntNext = freeCnt - cntT'(1);
        end
        else if (free && !alloc)
        begin
            freeCntNext = freeCnt + cntT'(1);
        end
    end

    // Stack of free tags; every tag is free after reset
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            freeCnt <= cntT'(Entries);
            notFull <= 1'b0;
            for (int i = 0; i < Entries; i++)
            begin
                freeStack[i] <= tagT'(i);
            end
        end
        else
        begin
            freeCnt <= freeCntNext;
            notFull <= (freeCntNext > cntT'(`RO_RESERVE));
            // A pop and a push together simply swap the freed tag onto the top
            if (alloc && free)
            begin
                freeStack[topPos] <= freeTag;
            end
            else if (free)
            begin
                freeStack[pushPos] <= freeTag;
            end
        end
    end

    // Metadata memory indexed by tag
    always_ff @(posedge clk)
    begin
        if (alloc)
        begin
            metaMem[allocTag] <= allocMeta;
        end
    end

    assign lookupMeta = metaMem[lookupTag];

endmodule

/* hw/reqTagger.sv */
// Request decode for both client channels.
// Requests pass to memory in the same cycle, with a tag in place of the metadata.
// With SYNC_CHANNELS set, a nearly full store on either channel stops both.

`timescale 1ns/1ps
`include "rsp_order_defs.svh"

module reqTagger
    import rspOrderPkg::*;
#(
    parameter int SYNC_CHANNELS = 1
)
(
    input  logic     clk,
    input  logic     arstN,
    input  rdReqT    rdReq,
    input  logic     rdReqValid,
    output logic     rdReqReady,
    input  wrReqT    wrReq,
    input  logic     wrReqValid,
    output logic     wrReqReady,
    output memRdReqT memRdReq,
    output logic     memRdReqValid,
    output memWrReqT memWrReq,
    output logic     memWrReqValid,
    input  tagT      rdAllocTag,
    input  logic     rdNotFull,
    output logic     allocRd,
    output metaT     allocRdMeta,
    input  tagT      wrLookupTag,
    output metaT     wrLookupMeta,
    input  logic     wrFree,
    input  tagT      wrFreeTag
);

    logic rdAccept;
    logic wrAccept;
    logic wrNotFull;
    tagT  wrAllocTag;

    // ====================
    // Ready generation
    // ====================

    // Both full flags are registered, so the readies never depend on valid
    generate
        if (SYNC_CHANNELS != 0)
        begin : genSync
            // Keeping the channels in step preserves load/store ordering
            assign rdReqReady = rdNotFull && wrNotFull;
            assign wrReqReady = rdNotFull && wrNotFull;
        end
        else
        begin : genSplit
            assign rdReqReady = rdNotFull;
            assign wrReqReady = wrNotFull;
        end
    endgenerate

    assign rdAccept = rdReqValid && rdReqReady;
    assign wrAccept = wrReqValid && wrReqReady;

    // ====================
    // Read channel
    // ====================

    // The reorder buffer saves the metadata in the slot behind the tag
    assign allocRd     = rdAccept;
    assign allocRdMeta = rdReq.meta;

    assign memRdReq      = '{addr: rdReq.addr, tag: rdAllocTag};
    assign memRdReqValid = rdAccept;

    // ====================
    // Write channel
    // ====================

    // Write metadata waits in the heap until the completion comes back
    tagHeap wrHeap (
        .clk        (clk),
        .arstN      (arstN),
        .alloc      (wrAccept),
        .allocMeta  (wrReq.meta),
        .allocTag   (wrAllocTag),
        .notFull    (wrNotFull),
        .lookupTag  (wrLookupTag),
        .lookupMeta (wrLookupMeta),
        .free       (wrFree),
        .freeTag    (wrFreeTag)
    );

    assign memWrReq      = '{addr: wrReq.addr, data: wrReq.data, tag: wrAllocTag};
    assign memWrReqValid = wrAccept;

endmodule

/* hw/reorderBuffer.sv */
// Reorder buffer for read data, a ring of slots addressed by tag.
// Lines leave in allocation order through one registered output stage.
// Memory must only return tags that are outstanding, each once.

`timescale 1ns/1ps
`include "rsp_order_defs.svh"

module reorderBuffer
    import rspOrderPkg::*;
(
    input  logic     clk,
    input  logic     arstN,
    input  logic     alloc,
    input  metaT     allocMeta,
    output tagT      allocTag,
    output logic     notFull,
    input  memRdRspT memRdRsp,
    input  logic     memRdRspValid,
    output rdRspT    rdRsp,
    output logic     rdRspValid,
    input  logic     rdRspReady
);

    localparam int Entries = `RO_ENTRIES;
    localparam int CntW = `RO_TAG_W + 1;

    typedef logic [CntW-1:0] cntT;

    metaT               metaMem [Entries];
    dataT               dataMem [Entries];
    logic [Entries-1:0] filled;
    tagT                allocIdx;
    tagT                headIdx;
    cntT                usedCnt;
    cntT                usedCntNext;
    logic               arriveHead;
    logic               headReady;
    logic               loadOut;
    dataT               headData;
    rdRspT              outReg;
    logic               outValid;

    // The tag of a new request is simply the allocate pointer
    assign allocTag = allocIdx;

    // ====================
    // Head selection
    // ====================

    // A line arriving for the head slot bypasses the memory, saving a cycle
    assign arriveHead = memRdRspValid && (memRdRsp.tag == headIdx);
    assign headReady  = (usedCnt != '0) && (filled[headIdx] || arriveHead);
    assign headData   = filled[headIdx] ? dataMem[headIdx] : memRdRsp.data;

    // Load the output stage when it is empty or being taken this cycle
    assign loadOut = headReady && (!outValid || rdRspReady);

    // Slots stay in use until their line moves into the output stage
    assign usedCntNext = usedCnt + cntT'(alloc) - cntT'(loadOut);

    // ====================
    // Control state
    // ====================

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            allocIdx <= '0;
            headIdx  <= '0;
            usedCnt  <= '0;
            filled   <= '0;
            outValid <= 1'b0;
            notFull  <= 1'b0;
        end
        else
        begin
            usedCnt <= usedCntNext;
            notFull <= ((cntT'(Entries) - usedCntNext) > cntT'(`RO_RESERVE));
            if (alloc)
            begin
                allocIdx <= allocIdx + tagT'(1);
            end
            if (memRdRspValid)
            begin
                filled[memRdRsp.tag] <= 1'b1;
            end
            // Clearing comes last so a bypassed head line is not left marked
            if (loadOut)
            begin
                filled[headIdx] <= 1'b0;
                headIdx         <= headIdx + tagT'(1);
                outValid        <= 1'b1;
            end
            else if (rdRspReady)
            begin
                outValid <= 1'b0;
            end
        end
    end

    // Slot payloads and the output line
    always_ff @(posedge clk)
    begin
        if (alloc)
        begin
            metaMem[allocIdx] <= allocMeta;
        end
        if (memRdRspValid)
        begin
            dataMem[memRdRsp.tag] <= memRdRsp.data;
        end
        if (loadOut)
        begin
            outReg <= '{data: headData, meta: metaMem[headIdx]};
        end
    end

    assign rdRsp      = outReg;
    assign rdRspValid = outValid;

endmodule

/* hw/rspRestore.sv */
// Write completion path: restores client metadata and queues the responses.
// Completions keep the order in which memory returns them.
// A tag goes back to the heap only when its response is delivered.

`timescale 1ns/1ps
`include "rsp_order_defs.svh"

module rspRestore
    import rspOrderPkg::*;
(
    input  logic  clk,
    input  logic  arstN,
    input  tagT   memWrRspTag,
    input  logic  memWrRspValid,
    output tagT   lookupTag,
    input  metaT  lookupMeta,
    output tagT   freeTag,
    output logic  free,
    output wrRspT wrRsp,
    output logic  wrRspValid,
    input  logic  wrRspReady
);

    localparam int Entries = `RO_ENTRIES;
    localparam int CntW = `RO_TAG_W + 1;

    typedef logic [CntW-1:0] cntT;

    metaT metaQ [Entries];
    tagT  tagQ [Entries];
    tagT  wrPtr;
    tagT  rdPtr;
    cntT  qCnt;
    logic push;
    logic pop;

    // The heap read port sees the completing tag directly
    assign lookupTag = memWrRspTag;

    assign push = memWrRspValid;
    assign pop  = wrRspValid && wrRspReady;

    // Holding each tag until delivery bounds the queue by the tag count,
    // even while the client stalls
    assign free    = pop;
    assign freeTag = tagQ[rdPtr];

    assign wrRspValid = (qCnt != '0);
    assign wrRsp      = '{meta: metaQ[rdPtr]};

    // ====================
    // Queue pointers
    // ====================

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            qCnt  <= '0;
        end
        else
        begin
            if (push)
            begin
                wrPtr <= wrPtr + tagT'(1);
            end
            if (pop)
            begin
                rdPtr <= rdPtr + tagT'(1);
            end
            qCnt <= qCnt + cntT'(push) - cntT'(pop);
        end
    end

    // Queue storage, restored metadata beside its tag
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            metaQ[wrPtr] <= lookupMeta;
            tagQ[wrPtr]  <= memWrRspTag;
        end
    end

endmodule

/* hw/rspOrderTop.sv */
// Response-ordering shim between a client and an out-of-order memory port.
// The memory side has no back-pressure; the tag count bounds what is in flight.
// Reads return in request order, writes in memory completion order.

`timescale 1ns/1ps
`include "rsp_order_defs.svh"

module rspOrderTop
    import rspOrderPkg::*;
#(
    parameter int SYNC_CHANNELS = 1
)
(
    input  logic     clk,
    input  logic     arstN,
    // Client requests
    input  rdReqT    rdReq,
    input  logic     rdReqValid,
    output logic     rdReqReady,
    input  wrReqT    wrReq,
    input  logic     wrReqValid,
    output logic     wrReqReady,
    // Client responses
    output rdRspT    rdRsp,
    output logic     rdRspValid,
    input  logic     rdRspReady,
    output wrRspT    wrRsp,
    output logic     wrRspValid,
    input  logic     wrRspReady,
    // Memory port
    output memRdReqT memRdReq,
    output logic     memRdReqValid,
    output memWrReqT memWrReq,
    output logic     memWrReqValid,
    input  memRdRspT memRdRsp,
    input  logic     memRdRspValid,
    input  tagT      memWrRspTag,
    input  logic     memWrRspValid
);

    // Links between the stages
    tagT  rdAllocTag;
    logic rdNotFull;
    logic allocRd;
    metaT allocRdMeta;
    tagT  wrLookupTag;
    metaT wrLookupMeta;
    logic wrFree;
    tagT  wrFreeTag;

    reqTagger #(
        .SYNC_CHANNELS (SYNC_CHANNELS)
    ) uTagger (
        .clk, .arstN,
        .rdReq, .rdReqValid, .rdReqReady,
        .wrReq, .wrReqValid, .wrReqReady,
        .memRdReq, .memRdReqValid,
        .memWrReq, .memWrReqValid,
        .rdAllocTag, .rdNotFull, .allocRd, .allocRdMeta,
        .wrLookupTag, .wrLookupMeta, .wrFree, .wrFreeTag
    );

    reorderBuffer uRob (
        .clk, .arstN,
        .alloc      (allocRd),
        .allocMeta  (allocRdMeta),
        .allocTag   (rdAllocTag),
        .notFull    (rdNotFull),
        .memRdRsp, .memRdRspValid,
        .rdRsp, .rdRspValid, .rdRspReady
    );

    rspRestore uRestore (
        .clk, .arstN,
        .memWrRspTag, .memWrRspValid,
        .lookupTag  (wrLookupTag),
        .lookupMeta (wrLookupMeta),
        .freeTag    (wrFreeTag),
        .free       (wrFree),
        .wrRsp, .wrRspValid, .wrRspReady
    );

endmodule

/* sim/rspOrder_chk.sv */
// Concurrent checks on the request decode stage, bound into reqTagger.
// Write tags are tracked from issue until the heap frees them.

`timescale 1ns/1ps
`include "rsp_order_defs.svh"

module rspOrderChk
    import rspOrderPkg::*;
#(
    parameter int SYNC_CHANNELS = 1
)
(
    input logic     clk,
    input logic     arstN,
    input logic     rdReqReady,
    input logic     memWrReqValid,
    input memWrReqT memWrReq,
    input logic     wrFree,
    input tagT      wrFreeTag
);

    // Most write tags that may be in flight at once
    localparam int WrLimit = `RO_ENTRIES - `RO_RESERVE;

    // One bit per write tag that memory still owns
    logic [`RO_ENTRIES-1:0] wrBusy;
    int                     wrOutCnt;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            wrBusy <= '0;
        end
        else
        begin
            if (wrFree)
            begin
                wrBusy[wrFreeTag] <= 1'b0;
            end
            if (memWrReqValid)
            begin
                wrBusy[memWrReq.tag] <= 1'b1;
            end
        end
    end

    // Outstanding writes counted apart from the heap's own counter
    assign wrOutCnt = $countones(wrBusy);

    // ====================
    // Properties
    // ====================

    // The heap must stop issuing before the reserve is used up
    wrIssueLimit: assert property (@(posedge clk) disable iff (!arstN)
        memWrReqValid |-> (wrOutCnt < WrLimit))
        else $error("write request issued with every usable write tag outstanding");

    // Synchronized channels stop reads as soon as the write heap is nearly full
    readySync: assert property (@(posedge clk) disable iff (!arstN)
        (SYNC_CHANNELS != 0 && rdReqReady) |-> (wrOutCnt < WrLimit))
        else $error("rdReqReady high while the write heap is nearly full");

    wrTagUnique: assert property (@(posedge clk) disable iff (!arstN)
        memWrReqValid |-> !wrBusy[memWrReq.tag])
        else $error("write tag allocated again while still outstanding");

endmodule

bind reqTagger rspOrderChk #(
    .SYNC_CHANNELS (SYNC_CHANNELS)
) uChk (
    .clk           (clk),
    .arstN         (arstN),
    .rdReqReady    (rdReqReady),
    .memWrReqValid (memWrReqValid),
    .memWrReq      (memWrReq),
    .wrFree        (wrFree),
    .wrFreeTag     (wrFreeTag)
);

/* sim/rspOrderTb.sv */
// Testbench for the response-ordering shim with an out-of-order memory model.
// Stimulus comes from an LCG with a fixed seed, so every run is the same.
// Read data from memory is the address XOR 32'h5a5a0000.

`timescale 1ns/1ps
`include "rsp_order_defs.svh"

module rspOrderTb
    import rspOrderPkg::*;
();

    localparam logic [31:0] Seed = 32'h08f1d36f;
    localparam int NumReads   = 300;
    localparam int NumWrites  = 300;
    localparam int BurstReads = 40;
    localparam int MaxDelay   = 12;
    localparam int FullAfter  = `RO_ENTRIES - `RO_RESERVE;
    // About 20 cycles per transfer is far above the expected rate
    localparam int CycleLimit = 20 * (NumReads + NumWrites + BurstReads) + 1000;

    // DUT ports
    logic     clk = 1'b0;
    logic     arstN = 1'b0;
    rdReqT    rdReq = '0;
    logic     rdReqValid = 1'b0;
    logic     rdReqReady;
    wrReqT    wrReq = '0;
    logic     wrReqValid = 1'b0;
    logic     wrReqReady;
    rdRspT    rdRsp;
    logic     rdRspValid;
    logic     rdRspReady = 1'b0;
    wrRspT    wrRsp;
    logic     wrRspValid;
    logic     wrRspReady = 1'b0;
    memRdReqT memRdReq;
    logic     memRdReqValid;
    memWrReqT memWrReq;
    logic     memWrReqValid;
    memRdRspT memRdRsp = '0;
    logic     memRdRspValid = 1'b0;
    tagT      memWrRspTag = '0;
    logic     memWrRspValid = 1'b0;

    // Sequence controls, changed only on falling edges
    bit    stimOn = 1'b0;
    bit    stallOn = 1'b0;
    bit    memHold = 1'b0;
    int    rdTarget = 0;
    int    wrTarget = 0;
    string curTest = "none";
    int    seqErr = 0;
    int    testsRun = 0;
    int    testsFailed = 0;
    int    errAtStart = 0;

    // Model state, owned by the clocked process
    logic [31:0] lcgState = Seed;
    int          now = 0;
    int          rdSent = 0;
    int          wrSent = 0;
    int          rdAccepted = 0;
    int          wrAccepted = 0;
    int          rdGot = 0;
    int          wrGot = 0;
    int          monErr = 0;
    int          cycles = 0;
    rdRspT       rdExpQ [$];
    metaT        wrExpQ [$];
    metaT        wrMetaByTag [`RO_ENTRIES];
    memRdReqT    rdPend [$];
    int          rdPendDue [$];
    tagT         wrPend [$];
    int          wrPendDue [$];

    rspOrderTop DUT (.*);

    always #10 clk = ~clk;

    // ====================
    // Helpers
    // ====================

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic int pickIndex(input int n);
        logic [31:0] r;
        r = nextRand();
        return int'(r[23:8]) % n;
    endfunction

    function automatic bit chance(input int pct);
        return pickIndex(100) < pct;
    endfunction

    // Data that the memory model returns for an address
    function automatic dataT readData(input addrT addr);
        return dataT'(addr) ^ 32'h5a5a0000;
    endfunction

    task automatic compareValue(input string name, input logic [63:0] expVal,
                                input logic [63:0] actVal, inout int errs);
        if (expVal !== actVal)
        begin
            $display("Error in test %s: %s expected 0x%0h, actual 0x%0h",
                     curTest, name, expVal, actVal);
            errs++;
        end
    endtask

    task automatic startTest(input string name);
        curTest = name;
        errAtStart = monErr + seqErr;
    endtask

    task automatic reportTest();
        int errs;
        errs = monErr + seqErr - errAtStart;
        testsRun++;
        if (errs == 0)
        begin
            $display("Test %s: ok", curTest);
        end
        else
        begin
            testsFailed++;
            $display("Test %s: failed with %0d errors", curTest, errs);
        end
    endtask

    task automatic checkIdle(input bit readiesLow);
        compareValue("rdRspValid", 64'd0, 64'(rdRspValid), seqErr);
        compareValue("wrRspValid", 64'd0, 64'(wrRspValid), seqErr);
        compareValue("memRdReqValid", 64'd0, 64'(memRdReqValid), seqErr);
        compareValue("memWrReqValid", 64'd0, 64'(memWrReqValid), seqErr);
        if (readiesLow)
        begin
            compareValue("rdReqReady", 64'd0, 64'(rdReqReady), seqErr);
            compareValue("wrReqReady", 64'd0, 64'(wrReqReady), seqErr);
        end
    endtask

    // ====================
    // Monitors, memory model and stimulus
    // ====================

    always @(posedge clk)
    begin : modelStep
        rdRspT       expRd;
        int          idx;
        logic [31:0] r1;
        logic [31:0] r2;
        if (arstN)
        begin
            now++;
            // Memory requests are same-cycle copies of accepted client requests
            compareValue("memRdReqValid", 64'(rdReqValid && rdReqReady),
                         64'(memRdReqValid), monErr);
            compareValue("memWrReqValid", 64'(wrReqValid && wrReqReady),
                         64'(memWrReqValid), monErr);
            compareValue("ready sync", 64'(rdReqReady), 64'(wrReqReady), monErr);

            if (rdReqValid && rdReqReady)
            begin
                rdAccepted++;
                compareValue("memRdReq addr", 64'(rdReq.addr), 64'(memRdReq.addr), monErr);
                rdExpQ.push_back('{data: readData(rdReq.addr), meta: rdReq.meta});
                rdPend.push_back(memRdReq);
                rdPendDue.push_back(now + 1 + pickIndex(MaxDelay));
            end
            if (wrReqValid && wrReqReady)
            begin
                wrAccepted++;
                compareValue("memWrReq addr", 64'(wrReq.addr), 64'(memWrReq.addr), monErr);
                compareValue("memWrReq data", 64'(wrReq.data), 64'(memWrReq.data), monErr);
                wrMetaByTag[memWrReq.tag] = wrReq.meta;
                wrPend.push_back(memWrReq.tag);
                wrPendDue.push_back(now + 1 + pickIndex(MaxDelay));
            end

            // Reads must come back in request order
            if (rdRspValid && rdRspReady)
            begin
                if (rdExpQ.size() == 0)
                begin
                    $display("Error in test %s: read response with no read outstanding",
                             curTest);
                    monErr++;
                end
                else
                begin
                    expRd = rdExpQ.pop_front();
                    compareValue("rdRsp data", 64'(expRd.data), 64'(rdRsp.data), monErr);
                    compareValue("rdRsp meta", 64'(expRd.meta), 64'(rdRsp.meta), monErr);
                end
                rdGot++;
            end
            // Writes follow the order in which memory completed them
            if (wrRspValid && wrRspReady)
            begin
                if (wrExpQ.size() == 0)
                begin
                    $display("Error in test %s: write response with no completion pending",
                             curTest);
                    monErr++;
                end
                else
                begin
                    compareValue("wrRsp meta", 64'(wrExpQ.pop_front()), 64'(wrRsp.meta),
                                 monErr);
                end
                wrGot++;
            end

            // Memory picks a random outstanding request once its delay has passed
            memRdRspValid <= 1'b0;
            if (!memHold && rdPend.size() > 0 && chance(60))
            begin
                idx = pickIndex(rdPend.size());
                if (rdPendDue[idx] <= now)
                begin
                    memRdRsp      <= '{tag: rdPend[idx].tag, data: readData(rdPend[idx].addr)};
                    memRdRspValid <= 1'b1;
                    rdPend.delete(idx);
                    rdPendDue.delete(idx);
                end
            end
            memWrRspValid <= 1'b0;
            if (!memHold && wrPend.size() > 0 && chance(60))
            begin
                idx = pickIndex(wrPend.size());
                if (wrPendDue[idx] <= now)
                begin
                    memWrRspTag   <= wrPend[idx];
                    memWrRspValid <= 1'b1;
                    wrExpQ.push_back(wrMetaByTag[wrPend[idx]]);
                    wrPend.delete(idx);
                    wrPendDue.delete(idx);
                end
            end

            // A request holds until it transfers
            if (!rdReqValid || rdReqReady)
            begin
                if (stimOn && rdSent < rdTarget && chance(50))
                begin
                    r1 = nextRand();
                    r2 = nextRand();
                    rdReq      <= '{addr: addrT'(r1 >> 8), meta: metaT'(r2)};
                    rdReqValid <= 1'b1;
                    rdSent++;
                end
                else
                begin
                    rdReqValid <= 1'b0;
                end
            end
            if (!wrReqValid || wrReqReady)
            begin
                if (stimOn && wrSent < wrTarget && chance(50))
                begin
                    r1 = nextRand();
                    r2 = nextRand();
                    wrReq      <= '{addr: addrT'(r1 >> 8), data: r2, meta: metaT'(r1)};
                    wrReqValid <= 1'b1;
                    wrSent++;
                end
                else
                begin
                    wrReqValid <= 1'b0;
                end
            end

            rdRspReady <= stallOn ? chance(70) : 1'b1;
            wrRspReady <= stallOn ? chance(70) : 1'b1;
        end
    end

    // Run limit
    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= CycleLimit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ====================
    // Test sequence
    // ====================

    initial
    begin : sequencer
        int rdBase;
        int wrBase;

        startTest("reset");
        repeat (8)
        begin
            @(negedge clk);
            checkIdle(1'b1);
        end
        @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        checkIdle(1'b0);
        @(negedge clk);
        compareValue("rdReqReady after reset", 64'd1, 64'(rdReqReady), seqErr);
        compareValue("wrReqReady after reset", 64'd1, 64'(wrReqReady), seqErr);
        // Nothing reaches memory without a client request
        repeat (4)
        begin
            @(negedge clk);
            checkIdle(1'b0);
        end
        reportTest();

        startTest("random traffic");
        rdBase = rdGot;
        wrBase = wrGot;
        stallOn = 1'b1;
        stimOn = 1'b1;
        rdTarget += NumReads;
        wrTarget += NumWrites;
        while (rdGot < rdTarget || wrGot < wrTarget)
        begin
            @(negedge clk);
        end
        // A few idle cycles expose late duplicates
        repeat (20) @(negedge clk);
        compareValue("reads returned", 64'(NumReads), 64'(rdGot - rdBase), seqErr);
        compareValue("writes returned", 64'(NumWrites), 64'(wrGot - wrBase), seqErr);
        // Every accepted request gets exactly one response
        compareValue("reads accepted", 64'(rdAccepted), 64'(rdGot), seqErr);
        compareValue("writes accepted", 64'(wrAccepted), 64'(wrGot), seqErr);
        compareValue("reads left", 64'd0, 64'(rdExpQ.size()), seqErr);
        compareValue("writes left", 64'd0, 64'(wrExpQ.size()), seqErr);
        reportTest();

        startTest("backpressure");
        stallOn = 1'b0;
        memHold = 1'b1;
        rdBase = rdAccepted;
        rdTarget += BurstReads;
        while (rdReqReady)
        begin
            @(negedge clk);
        end
        compareValue("reads before full", 64'(FullAfter), 64'(rdAccepted - rdBase), seqErr);
        compareValue("wrReqReady while full", 64'd0, 64'(wrReqReady), seqErr);
        repeat (5) @(negedge clk);
        compareValue("reads while held", 64'(FullAfter), 64'(rdAccepted - rdBase), seqErr);
        memHold = 1'b0;
        while (!(rdReqReady && wrReqReady))
        begin
            @(negedge clk);
        end
        while (rdGot < rdTarget)
        begin
            @(negedge clk);
        end
        compareValue("reads after release", 64'(BurstReads), 64'(rdAccepted - rdBase),
                     seqErr);
        reportTest();

        $display("Summary: %0d tests, %0d failed, %0d errors",
                 testsRun, testsFailed, monErr + seqErr);
        if (testsFailed == 0 && monErr + seqErr == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

/* rsp_order.f */
+incdir+hw
hw/rspOrderPkg.sv
hw/tagHeap.sv
hw/reqTagger.sv
hw/reorderBuffer.sv
hw/rspRestore.sv
hw/rspOrderTop.sv
sim/rspOrder_chk.sv
sim/rspOrderTb.sv

/* Makefile */
# Verilator build and run for the response-ordering shim

VERILATOR ?= verilator
TOP       ?= rspOrderTb
FILELIST  ?= rsp_order.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= Result: PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard hw/*.svh) $(FILELIST)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
